// File: source/spw_tx_pkg.sv
`default_nettype none

package spw_tx_pkg;

	// --------------------------------------------------------------------------
	// Widths
	// --------------------------------------------------------------------------
	localparam int state_w    = 3;
	localparam int cnt_w      = 4;
	localparam int credit_w   = 6;
	// Pending FCT requests not yet sent
	localparam int fct_pend_w = 4;

	// Transmit states, one per character kind or start-up phase
	localparam logic [state_w-1:0] tx_spw_start       = 3'b000;
	localparam logic [state_w-1:0] tx_spw_null        = 3'b001;
	localparam logic [state_w-1:0] tx_spw_fct         = 3'b010;
	localparam logic [state_w-1:0] tx_spw_null_c      = 3'b011;
	localparam logic [state_w-1:0] tx_spw_fct_c       = 3'b100;
	localparam logic [state_w-1:0] tx_spw_data_c      = 3'b101;
	localparam logic [state_w-1:0] tx_spw_data_c_0    = 3'b110;
	localparam logic [state_w-1:0] tx_spw_time_code_c = 3'b111;

	// Character lengths in bits
	localparam logic [cnt_w-1:0] len_data  = 4'd10;
	localparam logic [cnt_w-1:0] len_ctrl  = 4'd4;
	localparam logic [cnt_w-1:0] len_null  = 4'd8;
	localparam logic [cnt_w-1:0] len_tcode = 4'd14;

	// Control codes, bit 0 goes on the line first
	localparam logic [1:0] ctrl_fct = 2'b00;
	localparam logic [1:0] ctrl_esc = 2'b11;
	localparam logic [1:0] ctrl_eop = 2'b10;
	localparam logic [1:0] ctrl_eep = 2'b01;

	// --------------------------------------------------------------------------
	// Flow control and start-up
	// --------------------------------------------------------------------------
	localparam logic [credit_w-1:0] credit_step = 6'd8;
	localparam logic [credit_w-1:0] credit_max  = 6'd56;
	localparam logic [2:0] fct_init_count  = 3'd7;
	localparam logic [2:0] null_init_count = 3'd7;

endpackage

`default_nettype wire

// File: source/tx_data_send.sv
`timescale 1ns/1ps
`default_nettype none

module tx_data_send (
	input wire pclk_tx,
	input wire enable_tx,

	input wire [spw_tx_pkg::state_w-1:0] state_tx,
	input wire [spw_tx_pkg::cnt_w-1:0] global_counter_transfer,

	input wire [7:0] timecode_tx_i,
	input wire tickin_tx,

	input wire [8:0] data_tx_i,
	input wire txwrite_tx,

	input wire [spw_tx_pkg::credit_w-1:0] fct_counter_p,

	output logic [8:0] tx_data_in,
	output logic [8:0] tx_data_in_0,
	output logic process_data,
	output logic process_data_0,
	output logic [7:0] tx_tcode_in,
	output logic tcode_rdy_trnsp
);

	// Write level seen together with the buffer 1 sample
	logic write_seen;
	// At least one data character may go out
	logic credit_ok;

	assign credit_ok = (fct_counter_p != '0);

	// --------------------------------------------------------------------------
	// Send requests
	// --------------------------------------------------------------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			process_data    <= 1'b0;
			process_data_0  <= 1'b0;
			tcode_rdy_trnsp <= 1'b0;
			write_seen      <= 1'b0;
		end
		else
		begin
			case (state_tx)
				spw_tx_pkg::tx_spw_start, spw_tx_pkg::tx_spw_null, spw_tx_pkg::tx_spw_fct:
				begin
					// Nothing is offered before the link is up
					process_data    <= 1'b0;
					process_data_0  <= 1'b0;
					tcode_rdy_trnsp <= 1'b0;
					write_seen      <= 1'b0;
				end
				spw_tx_pkg::tx_spw_null_c, spw_tx_pkg::tx_spw_data_c_0,
				spw_tx_pkg::tx_spw_time_code_c:
				begin
					case (global_counter_transfer)
						4'd4:
						begin
							write_seen <= txwrite_tx;
						end
						4'd5:
						begin
							// Pending word moves to buffer 1
							process_data_0  <= 1'b0;
							process_data    <= write_seen && credit_ok;
							tcode_rdy_trnsp <= tickin_tx;
						end
						default:
						begin
						end
					endcase
				end
				spw_tx_pkg::tx_spw_fct_c:
				begin
					// Requests ride through FCTs untouched
				end
				spw_tx_pkg::tx_spw_data_c:
				begin
					case (global_counter_transfer)
						4'd1:
						begin
							// Buffer 1 is on the line now
							process_data   <= 1'b0;
							process_data_0 <= 1'b0;
						end
						4'd5:
						begin
							process_data_0 <= txwrite_tx && credit_ok;
						end
						default:
						begin
							tcode_rdy_trnsp <= 1'b0;
						end
					endcase
				end
			endcase
		end
	end

	// --------------------------------------------------------------------------
	// Character buffers and time code
	// --------------------------------------------------------------------------
	always_ff @(posedge pclk_tx)
	begin
		case (state_tx)
			spw_tx_pkg::tx_spw_null_c, spw_tx_pkg::tx_spw_data_c_0,
			spw_tx_pkg::tx_spw_time_code_c:
			begin
				tx_tcode_in <= timecode_tx_i;
				// Buffer 1 sampled one bit ahead of its request
				if (global_counter_transfer == 4'd4)
					tx_data_in <= data_tx_i;
			end
			spw_tx_pkg::tx_spw_data_c:
			begin
				tx_tcode_in <= timecode_tx_i;
				// Buffer 0 fills while buffer 1 is sent
				if (global_counter_transfer == 4'd5)
					tx_data_in_0 <= data_tx_i;
			end
			default:
			begin
			end
		endcase
	end

	// Requests only rise with credit in hand
	process_data_needs_credit: assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		$rose(process_data) |-> (fct_counter_p != '0)
	);

endmodule

`default_nettype wire

// File: source/tx_state_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tx_state_ctrl (
	input wire pclk_tx,
	input wire enable_tx,
	input wire char_done,
	input wire process_data,
	input wire process_data_0,
	input wire tcode_rdy_trnsp,
	input wire send_fct_req,
	output logic [spw_tx_pkg::state_w-1:0] state_tx
);

	// Start-up character count
	logic [2:0] init_cnt;
	logic [spw_tx_pkg::fct_pend_w-1:0] fct_pend;
	// Choice for the next connected character
	logic [spw_tx_pkg::state_w-1:0] next_conn;
	logic in_startup;
	logic enter_conn;
	logic take_fct;
	logic add_fct;

	// Time code first, then FCT, then data, NULL otherwise
	always_comb
	begin
		if (tcode_rdy_trnsp)
			next_conn = spw_tx_pkg::tx_spw_time_code_c;
		else if (fct_pend != '0)
			next_conn = spw_tx_pkg::tx_spw_fct_c;
		else if (process_data)
			next_conn = spw_tx_pkg::tx_spw_data_c;
		else if (process_data_0)
			next_conn = spw_tx_pkg::tx_spw_data_c_0;
		else
			next_conn = spw_tx_pkg::tx_spw_null_c;
	end

	assign in_startup = state_tx inside {spw_tx_pkg::tx_spw_start, spw_tx_pkg::tx_spw_null,
		spw_tx_pkg::tx_spw_fct};
	// Boundary where next_conn is taken, last start-up FCT included
	assign enter_conn = char_done && (!in_startup || (state_tx == spw_tx_pkg::tx_spw_fct
		&& init_cnt == spw_tx_pkg::fct_init_count - 3'd1));
	assign take_fct = enter_conn && (next_conn == spw_tx_pkg::tx_spw_fct_c);
	assign add_fct = send_fct_req && (!(&fct_pend) || take_fct);

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state_tx <= spw_tx_pkg::tx_spw_start;
			init_cnt <= '0;
			fct_pend <= '0;
		end
		else
		begin
			// Pending FCTs, saturating
			if (add_fct && !take_fct)
				fct_pend <= fct_pend + 1'b1;
			else if (take_fct && !add_fct)
				fct_pend <= fct_pend - 1'b1;

			if (enter_conn)
			begin
				state_tx <= next_conn;
				init_cnt <= '0;
			end
			else if (char_done)
			begin
				case (state_tx)
					spw_tx_pkg::tx_spw_start:
					begin
						state_tx <= spw_tx_pkg::tx_spw_null;
					end
					spw_tx_pkg::tx_spw_null:
					begin
						if (init_cnt == spw_tx_pkg::null_init_count - 3'd1)
						begin
							state_tx <= spw_tx_pkg::tx_spw_fct;
							init_cnt <= '0;
						end
						else
							init_cnt <= init_cnt + 3'd1;
					end
					default:
					begin
						// Start-up FCTs still running
						init_cnt <= init_cnt + 3'd1;
					end
				endcase
			end
		end
	end

	state_changes_on_boundary: assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		!$stable(state_tx) |-> $past(char_done)
	);

endmodule

`default_nettype wire

// File: source/tx_credit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tx_credit_counter (
	input wire pclk_tx,
	input wire enable_tx,
	input wire got_fct_rx,
	input wire data_sent,
	output logic [spw_tx_pkg::credit_w-1:0] fct_counter_p
);

	// One spare bit for the step overflow
	logic [spw_tx_pkg::credit_w:0] credit_sum;

	always_comb
	begin
		credit_sum = {1'b0, fct_counter_p};
		// Never below one when a data character starts
		if (data_sent)
			credit_sum = credit_sum - 1'b1;
		if (got_fct_rx)
			credit_sum = credit_sum + spw_tx_pkg::credit_step;
		// Clamp at the receiver buffer limit
		if (credit_sum > spw_tx_pkg::credit_max)
			credit_sum = {1'b0, spw_tx_pkg::credit_max};
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			fct_counter_p <= '0;
		else
			fct_counter_p <= credit_sum[spw_tx_pkg::credit_w-1:0];
	end

	// Shifter only starts data the request side cleared with credit
	no_data_without_credit: assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		data_sent |-> (fct_counter_p != '0)
	);

endmodule

`default_nettype wire

// File: source/tx_char_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module tx_char_shifter (
	input wire pclk_tx,
	input wire enable_tx,
	input wire [spw_tx_pkg::state_w-1:0] state_tx,
	input wire [8:0] tx_data_in,
	input wire [8:0] tx_data_in_0,
	input wire [7:0] tx_tcode_in,
	output logic [spw_tx_pkg::cnt_w-1:0] global_counter_transfer,
	output logic char_done,
	output logic data_sent,
	output logic data_taken,
	output logic tick_taken,
	output logic data_out,
	output logic strobe_out
);

	logic [spw_tx_pkg::len_tcode-1:0] char_vec;
	logic [spw_tx_pkg::len_tcode-1:0] shreg;
	logic [spw_tx_pkg::cnt_w-1:0] char_len;
	logic [spw_tx_pkg::cnt_w-1:0] len_q;
	logic [spw_tx_pkg::cnt_w-1:0] cur_len;
	// Parity of the data bits of the character being built
	logic char_par;
	// Same, for the character before
	logic par_prev;
	logic [8:0] word;
	logic silent_q;
	logic silent;
	logic start_char;
	logic bit_now;
	logic load_data;
	logic load_tick;

	assign word = (state_tx == spw_tx_pkg::tx_spw_data_c_0) ? tx_data_in_0 : tx_data_in;

	// --------------------------------------------------------------------------
	// Character build, bit 0 first on the line
	// --------------------------------------------------------------------------
	always_comb
	begin
		char_vec = '0;
		char_len = spw_tx_pkg::len_null;
		char_par = 1'b0;
		case (state_tx)
			spw_tx_pkg::tx_spw_null, spw_tx_pkg::tx_spw_null_c:
			begin
				// ESC then FCT, second parity bit covers the ESC code
				char_vec[spw_tx_pkg::len_null-1:0] = {spw_tx_pkg::ctrl_fct, 1'b1,
					~(^spw_tx_pkg::ctrl_esc ^ 1'b1), spw_tx_pkg::ctrl_esc, 1'b1,
					~(par_prev ^ 1'b1)};
			end
			spw_tx_pkg::tx_spw_fct, spw_tx_pkg::tx_spw_fct_c:
			begin
				char_vec[spw_tx_pkg::len_ctrl-1:0] = {spw_tx_pkg::ctrl_fct, 1'b1,
					~(par_prev ^ 1'b1)};
				char_len = spw_tx_pkg::len_ctrl;
			end
			spw_tx_pkg::tx_spw_data_c, spw_tx_pkg::tx_spw_data_c_0:
			begin
				// Flag sits in the control bit slot
				char_vec[spw_tx_pkg::len_data-1:0] = {word[7:0], word[8],
					~(par_prev ^ word[8])};
				char_len = spw_tx_pkg::len_data;
				char_par = ^word[7:0];
			end
			spw_tx_pkg::tx_spw_time_code_c:
			begin
				// ESC then a data-form character
				char_vec = {tx_tcode_in, 1'b0, ~(^spw_tx_pkg::ctrl_esc ^ 1'b0),
					spw_tx_pkg::ctrl_esc, 1'b1, ~(par_prev ^ 1'b1)};
				char_len = spw_tx_pkg::len_tcode;
				char_par = ^tx_tcode_in;
			end
			default:
			begin
				// Start period stays quiet on the line
			end
		endcase
	end

	assign start_char = (global_counter_transfer == '0);
	assign cur_len = start_char ? char_len : len_q;
	assign char_done = (global_counter_transfer == cur_len - 1'b1);
	assign silent = start_char ? (state_tx == spw_tx_pkg::tx_spw_start) : silent_q;
	assign bit_now = start_char ? char_vec[0] : shreg[0];

	always_ff @(posedge pclk_tx)
	begin
		if (start_char)
			shreg <= {1'b0, char_vec[spw_tx_pkg::len_tcode-1:1]};
		else
			shreg <= {1'b0, shreg[spw_tx_pkg::len_tcode-1:1]};
	end

	// --------------------------------------------------------------------------
	// Bit counter and Data-Strobe encoder
	// --------------------------------------------------------------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			global_counter_transfer <= '0;
			len_q      <= spw_tx_pkg::len_null;
			silent_q   <= 1'b1;
			par_prev   <= 1'b0;
			load_data  <= 1'b0;
			load_tick  <= 1'b0;
			data_out   <= 1'b0;
			strobe_out <= 1'b0;
		end
		else
		begin
			global_counter_transfer <= char_done ? '0 : global_counter_transfer + 1'b1;
			if (start_char)
			begin
				len_q    <= char_len;
				silent_q <= silent;
				par_prev <= char_par;
			end
			load_data <= start_char && (state_tx == spw_tx_pkg::tx_spw_data_c
				|| state_tx == spw_tx_pkg::tx_spw_data_c_0);
			load_tick <= start_char && (state_tx == spw_tx_pkg::tx_spw_time_code_c);
			if (!silent)
			begin
				data_out <= bit_now;
				// Strobe carries the edge when data repeats
				if (bit_now == data_out)
					strobe_out <= ~strobe_out;
			end
		end
	end

	assign data_sent = load_data;
	assign data_taken = load_data;
	assign tick_taken = load_tick;

endmodule

`default_nettype wire

// File: source/spw_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module spw_tx_top (
	input wire pclk_tx,
	input wire enable_tx,
	input wire [8:0] data_tx_i,
	input wire txwrite_tx,
	input wire [7:0] timecode_tx_i,
	input wire tickin_tx,
	input wire got_fct_rx,
	input wire send_fct_req,
	output logic data_out,
	output logic strobe_out,
	output logic data_taken,
	output logic tick_taken
);

	// Character framing
	logic [spw_tx_pkg::state_w-1:0] state_tx;
	logic [spw_tx_pkg::cnt_w-1:0] global_counter_transfer;
	logic char_done;

	// Buffers and requests
	logic [8:0] tx_data_in;
	logic [8:0] tx_data_in_0;
	logic [7:0] tx_tcode_in;
	logic process_data;
	logic process_data_0;
	logic tcode_rdy_trnsp;

	// Credit
	logic [spw_tx_pkg::credit_w-1:0] fct_counter_p;
	logic data_sent;

	tx_state_ctrl tx_state_ctrl_inst (
		.pclk_tx, .enable_tx, .char_done, .process_data, .process_data_0,
		.tcode_rdy_trnsp, .send_fct_req, .state_tx
	);

	tx_data_send tx_data_send_inst (
		.pclk_tx, .enable_tx, .state_tx, .global_counter_transfer,
		.timecode_tx_i, .tickin_tx, .data_tx_i, .txwrite_tx, .fct_counter_p,
		.tx_data_in, .tx_data_in_0, .process_data, .process_data_0,
		.tx_tcode_in, .tcode_rdy_trnsp
	);

	tx_credit_counter tx_credit_counter_inst (
		.pclk_tx, .enable_tx, .got_fct_rx, .data_sent, .fct_counter_p
	);

	tx_char_shifter tx_char_shifter_inst (
		.pclk_tx, .enable_tx, .state_tx, .tx_data_in, .tx_data_in_0, .tx_tcode_in,
		.global_counter_transfer, .char_done, .data_sent, .data_taken, .tick_taken,
		.data_out, .strobe_out
	);

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic pclk_tx,
	output logic enable_tx
);

	// 20 ns period, low phase first
	initial
	begin
		pclk_tx = 1'b0;
		forever
			#10 pclk_tx = ~pclk_tx;
	end

	// Reset held over three rising edges, released off the edge
	initial
	begin
		enable_tx = 1'b0;
		repeat (3)
			@(posedge pclk_tx);
		#2 enable_tx = 1'b1;
	end

endmodule

`default_nettype wire

// File: verification/tb_spw_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spw_checker (
	input wire pclk_tx,
	input wire enable_tx,
	input wire [8:0] data_tx_i,
	input wire [7:0] timecode_tx_i,
	input wire got_fct_rx,
	input wire send_fct_req,
	input wire data_out,
	input wire strobe_out,
	input wire data_taken,
	input wire tick_taken,
	output int error_count,
	output int data_seen,
	output int tcode_seen,
	output int fct_seen,
	output logic idle
);

	// Accepted words and time codes, oldest first
	logic [8:0] exp_data[$];
	logic [7:0] exp_tcode[$];
	// User inputs one sample back
	logic [8:0] data_q;
	logic [7:0] tcode_q;
	// Line levels one sample back
	logic d_q;
	logic s_q;
	// Character being framed, bit 0 first off the line
	logic [9:0] cbits;
	int nbits;
	int clen;
	logic is_data;
	// Parity of the data bits of the last character
	logic par_prev;
	logic esc_pend;
	// Characters since reset
	int events;
	int fct_rx_count;
	int fct_req_count;

	// Start-up order, then FCT bookkeeping
	task automatic note_char(input string kind);
		string due;
		due = (events < 7) ? "NULL" : "FCT";
		if (events < 14 && kind != due)
		begin
			error_count++;
			$display("Character %0d after reset is a %s, a %s was due", events, kind, due);
		end
		else if (events >= 14 && kind == "FCT")
			fct_seen++;
		events++;
	endtask

	task automatic close_char();
		logic [8:0] want;
		if (clen == 4)
		begin
			par_prev = cbits[2] ^ cbits[3];
			if ({cbits[3], cbits[2]} == spw_tx_pkg::ctrl_esc && !esc_pend)
				esc_pend = 1'b1;
			else if ({cbits[3], cbits[2]} == spw_tx_pkg::ctrl_fct)
			begin
				// ESC then FCT is a NULL
				note_char(esc_pend ? "NULL" : "FCT");
				esc_pend = 1'b0;
			end
			else
			begin
				error_count++;
				$display("Unexpected control code %b on the line", {cbits[3], cbits[2]});
				esc_pend = 1'b0;
			end
		end
		else
		begin
			par_prev = ^cbits[9:2];
			if (is_data)
			begin
				if (esc_pend)
				begin
					error_count++;
					$display("Data character follows an ESC");
				end
				esc_pend = 1'b0;
				note_char("data");
				data_seen++;
				if (data_seen > spw_tx_pkg::credit_step * fct_rx_count)
				begin
					error_count++;
					$display("Data character %0d sent beyond the credit of %0d FCTs received",
						data_seen, fct_rx_count);
				end
				if (exp_data.size() == 0)
				begin
					error_count++;
					$display("Data character on the line with no word accepted");
				end
				else
				begin
					want = exp_data.pop_front();
					if ({cbits[1], cbits[9:2]} !== want)
					begin
						error_count++;
						$display("ERR data_out data character: got %h expected %h",
							{cbits[1], cbits[9:2]}, want);
					end
				end
			end
			else
			begin
				// Data-form character after an ESC
				esc_pend = 1'b0;
				note_char("time code");
				tcode_seen++;
				if (exp_tcode.size() == 0)
				begin
					error_count++;
					$display("Time code on the line with none accepted");
				end
				else
				begin
					want = {1'b0, exp_tcode.pop_front()};
					if (cbits[9:2] !== want[7:0])
					begin
						error_count++;
						$display("ERR data_out time code: got %h expected %h",
							cbits[9:2], want[7:0]);
					end
				end
			end
		end
	endtask

	// One decoded bit, with the data handshake seen alongside it
	task automatic take_bit(input logic b, input logic mark);
		if (nbits == 0)
			is_data = mark;
		cbits[nbits] = b;
		nbits++;
		if (nbits == 2)
		begin
			// Length from handshake, flag and a pending ESC
			if (is_data || !b)
				clen = 10;
			else
				clen = 4;
			if (!is_data && !b && !esc_pend)
			begin
				error_count++;
				$display("Data-form character with neither data_taken nor an ESC before it");
			end
			// Odd parity over previous data bits, parity bit and flag
			if ((cbits[0] ^ par_prev ^ b) !== 1'b1)
			begin
				error_count++;
				$display("ERR data_out parity bit: got %h expected %h",
					cbits[0], ~(par_prev ^ b));
			end
		end
		else if (nbits == clen)
		begin
			close_char();
			nbits = 0;
		end
	endtask

	// --------------------------------------------------------------------------
	// Sampling at the rising edge, before the DUT updates
	// --------------------------------------------------------------------------
	always @(posedge pclk_tx)
	begin
		if (!enable_tx)
		begin
			exp_data.delete();
			exp_tcode.delete();
			data_q = '0;
			tcode_q = '0;
			d_q = 1'b0;
			s_q = 1'b0;
			cbits = '0;
			nbits = 0;
			clen = 0;
			is_data = 1'b0;
			par_prev = 1'b0;
			esc_pend = 1'b0;
			events = 0;
			fct_rx_count = 0;
			fct_req_count = 0;
			error_count = 0;
			data_seen = 0;
			tcode_seen = 0;
			fct_seen = 0;
		end
		else
		begin
			// Consume pulse rose one edge back, so the held value is one sample old
			if (data_taken)
				exp_data.push_back(data_q);
			if (tick_taken)
				exp_tcode.push_back(tcode_q);
			data_q = data_tx_i;
			tcode_q = timecode_tx_i;
			if (got_fct_rx)
				fct_rx_count++;
			if (send_fct_req)
				fct_req_count++;
			// Data-Strobe decode, one edge per bit
			if (data_out !== d_q && strobe_out !== s_q)
			begin
				error_count++;
				$display("ERR data_out and strobe_out changed together: data %h strobe %h",
					data_out, strobe_out);
			end
			else if (data_out !== d_q || strobe_out !== s_q)
				take_bit(data_out, data_taken);
			d_q = data_out;
			s_q = strobe_out;
		end
		idle = (events >= 14) && (exp_data.size() == 0) && (exp_tcode.size() == 0)
			&& (fct_seen == fct_req_count);
	end

endmodule

`default_nettype wire

// File: verification/tb_spw_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spw_tx;

	logic pclk_tx;
	logic enable_tx;
	logic [8:0] data_tx_i;
	logic txwrite_tx;
	logic [7:0] timecode_tx_i;
	logic tickin_tx;
	logic got_fct_rx;
	logic send_fct_req;
	wire data_out;
	wire strobe_out;
	wire data_taken;
	wire tick_taken;

	// Checker results
	int error_count;
	int data_seen;
	int tcode_seen;
	int fct_seen;
	logic idle;

	int seed;
	int tb_errors;
	int n;
	int cycle_n;
	logic done;

	tb_clock_gen tb_clock_gen_inst (.pclk_tx, .enable_tx);

	spw_tx_top spw_tx_top_inst (
		.pclk_tx, .enable_tx, .data_tx_i, .txwrite_tx, .timecode_tx_i, .tickin_tx,
		.got_fct_rx, .send_fct_req, .data_out, .strobe_out, .data_taken, .tick_taken
	);

	tb_spw_checker tb_spw_checker_inst (
		.pclk_tx, .enable_tx, .data_tx_i, .timecode_tx_i, .got_fct_rx, .send_fct_req,
		.data_out, .strobe_out, .data_taken, .tick_taken,
		.error_count, .data_seen, .tcode_seen, .fct_seen, .idle
	);

	// --------------------------------------------------------------------------
	// User side, one call per clock, 2 ns after the rising edge
	// --------------------------------------------------------------------------
	task automatic drive_cycle(input logic allow_new);
		got_fct_rx = 1'b0;
		send_fct_req = 1'b0;
		// Offers end on their consume pulse
		if (data_taken)
			txwrite_tx = 1'b0;
		if (tick_taken)
			tickin_tx = 1'b0;
		else if (allow_new && !tickin_tx && ($random(seed) % 60) == 0)
		begin
			// Value and level change together
			timecode_tx_i = $random(seed);
			tickin_tx = 1'b1;
		end
		if (allow_new && !txwrite_tx && ($random(seed) % 3) == 0)
		begin
			data_tx_i = $random(seed);
			txwrite_tx = 1'b1;
		end
		// Sparse credit, so back-pressure shows up
		if (($random(seed) % 90) == 0)
			got_fct_rx = 1'b1;
		if (allow_new && ($random(seed) % 40) == 0)
			send_fct_req = 1'b1;
	endtask

	initial
	begin
		seed = 32'h3330_b7b4;
		tb_errors = 0;
		data_tx_i = '0;
		txwrite_tx = 1'b0;
		timecode_tx_i = '0;
		tickin_tx = 1'b0;
		got_fct_rx = 1'b0;
		send_fct_req = 1'b0;

		n = 0;
		while (enable_tx !== 1'b1 && n < 20)
		begin
			@(posedge pclk_tx);
			n++;
		end
		if (enable_tx !== 1'b1)
		begin
			tb_errors++;
			$display("Timeout waiting for enable_tx to rise");
		end
		else
		begin
			for (cycle_n = 0; cycle_n < 3000; cycle_n++)
			begin
				@(posedge pclk_tx);
				#2;
				drive_cycle(1'b1);
			end
			// Held word and time code must still go out
			n = 0;
			while ((txwrite_tx || tickin_tx) && n < 2000)
			begin
				@(posedge pclk_tx);
				#2;
				drive_cycle(1'b0);
				n++;
			end
			if (txwrite_tx || tickin_tx)
			begin
				tb_errors++;
				$display("Timeout waiting for data_taken or tick_taken on the last offer");
			end
			else
			begin
				// Line drains, pending FCTs included
				n = 0;
				done = 1'b0;
				while (!done && n < 2000)
				begin
					@(posedge pclk_tx);
					#2;
					drive_cycle(1'b0);
					done = idle;
					n++;
				end
				if (!done)
				begin
					tb_errors++;
					$display("Timeout waiting for all accepted characters and FCTs on the line");
				end
				if (data_seen == 0 || tcode_seen == 0)
				begin
					tb_errors++;
					$display("No data character or no time code reached the line");
				end
			end
		end

		$display("Checked %0d data, %0d time codes, %0d FCTs: %0d checker errors, %0d tb errors",
			data_seen, tcode_seen, fct_seen, error_count, tb_errors);
		if (error_count == 0 && tb_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
source/spw_tx_pkg.sv
source/tx_data_send.sv
source/tx_state_ctrl.sv
source/tx_credit_counter.sv
source/tx_char_shifter.sv
source/spw_tx_top.sv
verification/tb_clock_gen.sv
verification/tb_spw_checker.sv
verification/tb_spw_tx.sv

// File: Bender.yml
package:
  name: spw_tx

sources:
  # Transmit RTL, package first
  - files:
      - source/spw_tx_pkg.sv
      - source/tx_data_send.sv
      - source/tx_state_ctrl.sv
      - source/tx_credit_counter.sv
      - source/tx_char_shifter.sv
      - source/spw_tx_top.sv

  # Testbench
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_spw_checker.sv
      - verification/tb_spw_tx.sv
